// ==== logic/csr_pkg.sv ====
package csr_pkg;

    // Datapath and CSR number widths
    localparam int XLEN      = 32;
    localparam int CSR_NUM_W = 14;

    // CSR numbers
    localparam logic [CSR_NUM_W-1:0] CSR_CRMD   = 14'h000;
    localparam logic [CSR_NUM_W-1:0] CSR_PRMD   = 14'h001;
    localparam logic [CSR_NUM_W-1:0] CSR_ECFG   = 14'h004;
    localparam logic [CSR_NUM_W-1:0] CSR_ESTAT  = 14'h005;
    localparam logic [CSR_NUM_W-1:0] CSR_ERA    = 14'h006;
    localparam logic [CSR_NUM_W-1:0] CSR_EENTRY = 14'h00c;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE0  = 14'h030; // SAVEk sits at CSR_SAVE0 + k
    localparam logic [CSR_NUM_W-1:0] CSR_TCFG   = 14'h041;
    localparam logic [CSR_NUM_W-1:0] CSR_TVAL   = 14'h042;
    localparam logic [CSR_NUM_W-1:0] CSR_TICLR  = 14'h044;

    localparam int SAVE_COUNT_DEFAULT = 4;

    // CRMD is PLV[1:0], IE, DA, PG, DATF[6:5], DATM[8:7]
    localparam int CRMD_W = 9;
    localparam logic [CRMD_W-1:0] CRMD_RESET = 9'h008; // DA set
    // PRMD is PPLV[1:0], PIE
    localparam int PRMD_W = 3;

    // Interrupt status and enable
    localparam int IS_W      = 13;
    localparam logic [IS_W-1:0] LIE_MASK = 13'h1bff; // Bit 10 reserved
    localparam int IS_TIMER  = 11;
    localparam int IS_SOFT_W = 2;

    // One-hot cause vector from the pipeline
    localparam int EXC_W    = 5;
    localparam int EXC_INT  = 0;
    localparam int EXC_SYS  = 1;
    localparam int EXC_BRK  = 2;
    localparam int EXC_INE  = 3;
    localparam int EXC_ADEF = 4;

    // Architectural codes as recorded in ESTAT
    localparam int ECODE_W    = 6;
    localparam int ESUBCODE_W = 9;

    localparam logic [ECODE_W-1:0] ECODE_INT = 6'h00;
    localparam logic [ECODE_W-1:0] ECODE_ADE = 6'h08;
    localparam logic [ECODE_W-1:0] ECODE_SYS = 6'h0b;
    localparam logic [ECODE_W-1:0] ECODE_BRK = 6'h0c;
    localparam logic [ECODE_W-1:0] ECODE_INE = 6'h0d;

    localparam logic [ESUBCODE_W-1:0] ESUBCODE_ADEF = 9'h000;

    // Exception entry alignment, low bits of EENTRY
    localparam int ENTRY_ALIGN = 6;

endpackage

// ==== logic/csr_exc_unit.sv ====
module csr_exc_unit (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  logic                                                  csr_we,
    input  logic [csr_pkg::CSR_NUM_W-1:0]                         csr_num,
    input  logic [csr_pkg::XLEN-1:0]                              csr_mask,
    input  logic [csr_pkg::XLEN-1:0]                              csr_wdata,
    input  logic                                                  exc_valid,
    input  logic [csr_pkg::EXC_W-1:0]                             exc_vec,
    input  logic [csr_pkg::XLEN-1:0]                              exc_pc,
    input  logic                                                  ertn,
    output logic [csr_pkg::CRMD_W-1:0]                            crmd,
    output logic [csr_pkg::PRMD_W-1:0]                            prmd,
    output logic [csr_pkg::XLEN-1:0]                              era,
    output logic [csr_pkg::XLEN-1:0]                              eentry,
    output logic [csr_pkg::ESUBCODE_W+csr_pkg::ECODE_W-1:0]       estat_code,
    output logic                                                  crmd_ie,
    output logic [csr_pkg::XLEN-1:0]                              exception_pc,
    output logic                                                  flush
);
    import csr_pkg::*;

    logic [CRMD_W-1:0]          crmd_q;
    logic [PRMD_W-1:0]          prmd_q;
    logic [XLEN-1:0]            era_q;
    logic [XLEN-1:ENTRY_ALIGN]  eentry_va;
    logic [ECODE_W-1:0]         ecode_q;
    logic [ESUBCODE_W-1:0]      esubcode_q;

    logic [ECODE_W-1:0]         ecode;
    logic [ESUBCODE_W-1:0]      esubcode;
    logic                       exc_ret;
    logic                       crmd_wr;
    logic                       prmd_wr;
    logic                       era_wr;
    logic                       eentry_wr;

    assign exc_ret   = ertn & ~exc_valid; // Entry beats return
    assign crmd_wr   = csr_we && (csr_num == CSR_CRMD);
    assign prmd_wr   = csr_we && (csr_num == CSR_PRMD);
    assign era_wr    = csr_we && (csr_num == CSR_ERA);
    assign eentry_wr = csr_we && (csr_num == CSR_EENTRY);

    // Highest priority cause first, INT is the default
    always_comb begin
        ecode    = ECODE_INT;
        esubcode = '0;
        if (exc_vec[EXC_ADEF]) begin
            ecode    = ECODE_ADE;
            esubcode = ESUBCODE_ADEF;
        end else if (exc_vec[EXC_INE]) begin
            ecode = ECODE_INE;
        end else if (exc_vec[EXC_BRK]) begin
            ecode = ECODE_BRK;
        end else if (exc_vec[EXC_SYS]) begin
            ecode = ECODE_SYS;
        end
    end

    // Software write first, exception or return then overrides PLV/IE
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_q <= CRMD_RESET;
        end else begin
            if (crmd_wr)
                crmd_q <= (csr_mask[CRMD_W-1:0] & csr_wdata[CRMD_W-1:0]) |
                          (~csr_mask[CRMD_W-1:0] & crmd_q);
            if (exc_valid)
                crmd_q[PRMD_W-1:0] <= '0;
            else if (exc_ret)
                crmd_q[PRMD_W-1:0] <= prmd_q;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_q <= '0;
        end else if (exc_valid) begin
            prmd_q <= crmd_q[PRMD_W-1:0]; // Save PLV/IE
        end else if (prmd_wr) begin
            prmd_q <= (csr_mask[PRMD_W-1:0] & csr_wdata[PRMD_W-1:0]) |
                      (~csr_mask[PRMD_W-1:0] & prmd_q);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            era_q <= '0;
        end else if (exc_valid) begin
            era_q <= exc_pc;
        end else if (era_wr) begin
            era_q <= (csr_mask & csr_wdata) | (~csr_mask & era_q);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            eentry_va <= '0;
        end else if (eentry_wr) begin
            eentry_va <= (csr_mask[XLEN-1:ENTRY_ALIGN] & csr_wdata[XLEN-1:ENTRY_ALIGN]) |
                         (~csr_mask[XLEN-1:ENTRY_ALIGN] & eentry_va);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ecode_q    <= '0;
            esubcode_q <= '0;
        end else if (exc_valid) begin
            ecode_q    <= ecode;
            esubcode_q <= esubcode;
        end
    end

    assign crmd       = crmd_q;
    assign crmd_ie    = crmd_q[2];
    assign prmd       = prmd_q;
    assign era        = era_q;
    assign eentry     = {eentry_va, {ENTRY_ALIGN{1'b0}}};
    assign estat_code = {esubcode_q, ecode_q};

    assign flush        = exc_valid | ertn;
    assign exception_pc = exc_valid ? eentry : (ertn ? era_q : '0);

endmodule

// ==== logic/csr_timer.sv ====
module csr_timer #(
    parameter int TIMER_W = 32
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          csr_we,
    input  logic [csr_pkg::CSR_NUM_W-1:0] csr_num,
    input  logic [csr_pkg::XLEN-1:0]      csr_mask,
    input  logic [csr_pkg::XLEN-1:0]      csr_wdata,
    output logic [TIMER_W-1:0]            tcfg,
    output logic [TIMER_W-1:0]            tval,
    output logic                          timer_pending
);
    import csr_pkg::*;

    logic                  tcfg_en;
    logic [TIMER_W-1:1]    tcfg_cfg;   // Periodic at bit 1, InitVal above
    logic [TIMER_W-1:0]    tcfg_next;
    logic [TIMER_W-1:0]    tval_q;
    logic [TIMER_W-1:0]    reload_val;
    logic                  tcfg_wr;
    logic                  ticlr_clr;
    logic                  tval_zero;
    logic                  tval_stopped;

    assign tcfg_wr   = csr_we && (csr_num == CSR_TCFG);
    assign ticlr_clr = csr_we && (csr_num == CSR_TICLR) && csr_mask[0] && csr_wdata[0];

    assign tcfg_next = (csr_mask[TIMER_W-1:0] & csr_wdata[TIMER_W-1:0]) |
                       (~csr_mask[TIMER_W-1:0] & {tcfg_cfg, tcfg_en});

    assign reload_val   = {tcfg_cfg[TIMER_W-1:2], 2'b00}; // InitVal times 4
    assign tval_zero    = (tval_q == '0);
    assign tval_stopped = (tval_q == '1);

    always_ff @(posedge clk) begin
        if (reset)
            tcfg_en <= 1'b0;
        else if (tcfg_wr)
            tcfg_en <= tcfg_next[0];
    end

    always_ff @(posedge clk) begin
        if (tcfg_wr)
            tcfg_cfg <= tcfg_next[TIMER_W-1:1];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tval_q <= '1;
        end else if (tcfg_wr && tcfg_next[0]) begin
            tval_q <= {tcfg_next[TIMER_W-1:2], 2'b00};
        end else if (tcfg_en && tcfg_cfg[1] && tval_zero) begin
            tval_q <= reload_val; // Periodic reload
        end else if (tcfg_en && !tval_stopped) begin
            tval_q <= tval_q - TIMER_W'(1); // One-shot parks at all ones
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            timer_pending <= 1'b0;
        else if (tval_zero)
            timer_pending <= 1'b1;
        else if (ticlr_clr)
            timer_pending <= 1'b0;
    end

    assign tcfg = {tcfg_cfg, tcfg_en};
    assign tval = tval_q;

endmodule

// ==== logic/csr_irq.sv ====
module csr_irq (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          csr_we,
    input  logic [csr_pkg::CSR_NUM_W-1:0] csr_num,
    input  logic [csr_pkg::XLEN-1:0]      csr_mask,
    input  logic [csr_pkg::XLEN-1:0]      csr_wdata,
    input  logic                          timer_pending,
    input  logic                          crmd_ie,
    output logic [csr_pkg::IS_W-1:0]      is_bits,
    output logic [csr_pkg::IS_W-1:0]      lie,
    output logic                          csr_interrupt
);
    import csr_pkg::*;

    logic [IS_SOFT_W-1:0] soft_is;
    logic [IS_W-1:0]      lie_q;
    logic                 estat_wr;
    logic                 ecfg_wr;

    assign estat_wr = csr_we && (csr_num == CSR_ESTAT);
    assign ecfg_wr  = csr_we && (csr_num == CSR_ECFG);

    // Only the software bits of ESTAT.IS are writable
    always_ff @(posedge clk) begin
        if (reset)
            soft_is <= '0;
        else if (estat_wr)
            soft_is <= (csr_mask[IS_SOFT_W-1:0] & csr_wdata[IS_SOFT_W-1:0]) |
                       (~csr_mask[IS_SOFT_W-1:0] & soft_is);
    end

    always_ff @(posedge clk) begin
        if (reset)
            lie_q <= '0;
        else if (ecfg_wr)
            lie_q <= ((csr_mask[IS_W-1:0] & csr_wdata[IS_W-1:0]) |
                      (~csr_mask[IS_W-1:0] & lie_q)) & LIE_MASK;
    end

    // Hardware and IPI lines are not wired in this core
    always_comb begin
        is_bits                  = '0;
        is_bits[IS_SOFT_W-1:0]   = soft_is;
        is_bits[IS_TIMER]        = timer_pending;
    end

    assign lie           = lie_q;
    assign csr_interrupt = crmd_ie & |(is_bits & lie_q);

endmodule

// ==== logic/csr_scratch.sv ====
module csr_scratch #(
    parameter int SAVE_COUNT = 4
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         csr_we,
    input  logic [csr_pkg::CSR_NUM_W-1:0]                csr_num,
    input  logic [csr_pkg::XLEN-1:0]                     csr_mask,
    input  logic [csr_pkg::XLEN-1:0]                     csr_wdata,
    output logic [SAVE_COUNT-1:0][csr_pkg::XLEN-1:0]     save_data
);
    import csr_pkg::*;

    for (genvar k = 0; k < SAVE_COUNT; k++) begin : g_save
        logic sel;

        assign sel = csr_we && (csr_num == CSR_SAVE0 + CSR_NUM_W'(k));

        always_ff @(posedge clk) begin
            if (reset)
                save_data[k] <= '0;
            else if (sel)
                save_data[k] <= (csr_mask & csr_wdata) | (~csr_mask & save_data[k]);
        end
    end

endmodule

// ==== logic/csr_read_mux.sv ====
module csr_read_mux #(
    parameter int SAVE_COUNT = 4,
    parameter int TIMER_W    = 32
) (
    input  logic [csr_pkg::CSR_NUM_W-1:0]                   csr_num,
    input  logic [csr_pkg::CRMD_W-1:0]                      crmd,
    input  logic [csr_pkg::PRMD_W-1:0]                      prmd,
    input  logic [csr_pkg::XLEN-1:0]                        era,
    input  logic [csr_pkg::XLEN-1:0]                        eentry,
    input  logic [csr_pkg::ESUBCODE_W+csr_pkg::ECODE_W-1:0] estat_code,
    input  logic [csr_pkg::IS_W-1:0]                        is_bits,
    input  logic [csr_pkg::IS_W-1:0]                        lie,
    input  logic [TIMER_W-1:0]                              tcfg,
    input  logic [TIMER_W-1:0]                              tval,
    input  logic [SAVE_COUNT-1:0][csr_pkg::XLEN-1:0]        save_data,
    output logic [csr_pkg::XLEN-1:0]                        csr_rdata
);
    import csr_pkg::*;

    always_comb begin
        csr_rdata = '0;
        case (csr_num)
            CSR_CRMD:   csr_rdata = XLEN'(crmd);
            CSR_PRMD:   csr_rdata = XLEN'(prmd);
            CSR_ESTAT:  csr_rdata = {1'b0, estat_code, 3'b000, is_bits};
            CSR_ERA:    csr_rdata = era;
            CSR_EENTRY: csr_rdata = eentry;
            CSR_ECFG:   csr_rdata = XLEN'(lie);
            CSR_TCFG:   csr_rdata = XLEN'(tcfg);
            CSR_TVAL:   csr_rdata = XLEN'(tval);
            default:    csr_rdata = '0; // TICLR and unknown numbers
        endcase

        // Scratch bank occupies a run of numbers from SAVE0
        for (int k = 0; k < SAVE_COUNT; k++) begin
            if (csr_num == CSR_SAVE0 + CSR_NUM_W'(k))
                csr_rdata = save_data[k];
        end
    end

endmodule

// ==== logic/csr_top.sv ====
module csr_top #(
    parameter int SAVE_COUNT = csr_pkg::SAVE_COUNT_DEFAULT,
    parameter int TIMER_W    = 32
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          csr_we,
    input  logic [csr_pkg::CSR_NUM_W-1:0] csr_num,
    input  logic [csr_pkg::XLEN-1:0]      csr_mask,
    input  logic [csr_pkg::XLEN-1:0]      csr_wdata,
    input  logic                          exc_valid,
    input  logic [csr_pkg::EXC_W-1:0]     exc_vec,
    input  logic [csr_pkg::XLEN-1:0]      exc_pc,
    input  logic                          ertn,
    output logic [csr_pkg::XLEN-1:0]      csr_rdata,
    output logic [csr_pkg::XLEN-1:0]      exception_pc,
    output logic                          flush,
    output logic                          csr_interrupt
);
    import csr_pkg::*;

    logic [CRMD_W-1:0]                crmd;
    logic [PRMD_W-1:0]                prmd;
    logic [XLEN-1:0]                  era;
    logic [XLEN-1:0]                  eentry;
    logic [ESUBCODE_W+ECODE_W-1:0]    estat_code;
    logic                             crmd_ie;
    logic                             timer_pending;
    logic [IS_W-1:0]                  is_bits;
    logic [IS_W-1:0]                  lie;
    logic [TIMER_W-1:0]               tcfg;
    logic [TIMER_W-1:0]               tval;
    logic [SAVE_COUNT-1:0][XLEN-1:0]  save_data;

    csr_exc_unit u_exc (
        .clk          (clk),
        .reset        (reset),
        .csr_we       (csr_we),
        .csr_num      (csr_num),
        .csr_mask     (csr_mask),
        .csr_wdata    (csr_wdata),
        .exc_valid    (exc_valid),
        .exc_vec      (exc_vec),
        .exc_pc       (exc_pc),
        .ertn         (ertn),
        .crmd         (crmd),
        .prmd         (prmd),
        .era          (era),
        .eentry       (eentry),
        .estat_code   (estat_code),
        .crmd_ie      (crmd_ie),
        .exception_pc (exception_pc),
        .flush        (flush)
    );

    csr_timer #(
        .TIMER_W (TIMER_W)
    ) u_timer (
        .clk           (clk),
        .reset         (reset),
        .csr_we        (csr_we),
        .csr_num       (csr_num),
        .csr_mask      (csr_mask),
        .csr_wdata     (csr_wdata),
        .tcfg          (tcfg),
        .tval          (tval),
        .timer_pending (timer_pending)
    );

    csr_irq u_irq (
        .clk           (clk),
        .reset         (reset),
        .csr_we        (csr_we),
        .csr_num       (csr_num),
        .csr_mask      (csr_mask),
        .csr_wdata     (csr_wdata),
        .timer_pending (timer_pending),
        .crmd_ie       (crmd_ie),
        .is_bits       (is_bits),
        .lie           (lie),
        .csr_interrupt (csr_interrupt)
    );

    csr_scratch #(
        .SAVE_COUNT (SAVE_COUNT)
    ) u_scratch (
        .clk       (clk),
        .reset     (reset),
        .csr_we    (csr_we),
        .csr_num   (csr_num),
        .csr_mask  (csr_mask),
        .csr_wdata (csr_wdata),
        .save_data (save_data)
    );

    csr_read_mux #(
        .SAVE_COUNT (SAVE_COUNT),
        .TIMER_W    (TIMER_W)
    ) u_rmux (
        .csr_num    (csr_num),
        .crmd       (crmd),
        .prmd       (prmd),
        .era        (era),
        .eentry     (eentry),
        .estat_code (estat_code),
        .is_bits    (is_bits),
        .lie        (lie),
        .tcfg       (tcfg),
        .tval       (tval),
        .save_data  (save_data),
        .csr_rdata  (csr_rdata)
    );

endmodule

// ==== tb/csr_tb_tasks.svh ====
`ifndef CSR_TB_TASKS_SVH
`define CSR_TB_TASKS_SVH

// Drive point of the next cycle
task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
endtask

task automatic csr_write(input logic [CSR_NUM_W-1:0] num, input logic [31:0] mask,
                         input logic [31:0] data);
    csr_we    = 1'b1;
    csr_num   = num;
    csr_mask  = mask;
    csr_wdata = data;
    next_cycle();
    csr_we    = 1'b0;
    csr_mask  = '0;
    csr_wdata = '0;
endtask

// Read data is combinational, sampled mid-cycle
task automatic csr_check(input logic [CSR_NUM_W-1:0] num, input logic [31:0] expected,
                         input string name);
    csr_num = num;
    #SAMPLE_DLY;
    assert (csr_rdata === expected) else report_mismatch(name, expected, csr_rdata);
    next_cycle();
endtask

task automatic check_irq();
    csr_num = CSR_ESTAT;
    #SAMPLE_DLY;
    assert (csr_rdata === estat_expected())
        else report_mismatch("estat", estat_expected(), csr_rdata);
    assert (csr_interrupt === irq_expected())
        else report_mismatch("csr_interrupt", 32'(irq_expected()), 32'(csr_interrupt));
    next_cycle();
endtask

task automatic take_exception(input logic [EXC_W-1:0] vec, input logic [31:0] pc);
    exc_valid = 1'b1;
    exc_vec   = vec;
    exc_pc    = pc;
    #SAMPLE_DLY;
    assert (flush === 1'b1) else report_mismatch("flush", 32'h1, 32'(flush));
    assert (exception_pc === exp_eentry)
        else report_mismatch("exception_pc", exp_eentry, exception_pc);
    next_cycle();
    exc_valid                = 1'b0;
    exc_vec                  = '0;
    exp_prmd                 = exp_crmd[2:0]; // PLV/IE saved
    exp_crmd[2:0]            = 3'b000;
    exp_era                  = pc;
    {exp_subcode, exp_ecode} = expected_code(vec);
endtask

task automatic take_ertn();
    ertn = 1'b1;
    #SAMPLE_DLY;
    assert (flush === 1'b1) else report_mismatch("flush", 32'h1, 32'(flush));
    assert (exception_pc === exp_era)
        else report_mismatch("exception_pc", exp_era, exception_pc);
    next_cycle();
    ertn          = 1'b0;
    exp_crmd[2:0] = exp_prmd;
endtask

`endif

// ==== tb/csr_tb.sv ====
module csr_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import csr_pkg::*;

    localparam int CLK_PERIOD     = 100;
    localparam int DRIVE_DLY      = 10;
    localparam int SAMPLE_DLY     = 40; // Mid-cycle
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int SAVE_N         = SAVE_COUNT_DEFAULT;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 csr_we;
    logic [CSR_NUM_W-1:0] csr_num;
    logic [31:0]          csr_mask;
    logic [31:0]          csr_wdata;
    logic                 exc_valid;
    logic [EXC_W-1:0]     exc_vec;
    logic [31:0]          exc_pc;
    logic                 ertn;
    logic [31:0]          csr_rdata;
    logic [31:0]          exception_pc;
    logic                 flush;
    logic                 csr_interrupt;

    // Expected architectural state
    logic [31:0] exp_save [SAVE_N];
    logic [31:0] exp_era;
    logic [31:0] exp_eentry;
    logic [8:0]  exp_crmd;
    logic [2:0]  exp_prmd;
    logic [12:0] exp_lie;
    logic [1:0]  exp_soft;
    logic        exp_tpend;
    logic [5:0]  exp_ecode;
    logic [8:0]  exp_subcode;
    int          cycle_count = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    csr_top #(.SAVE_COUNT(SAVE_N), .TIMER_W(32)) u_dut (.*);

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("mismatch at %0t: %s expected 0x%08h actual 0x%08h",
                 $time, name, expected, actual);
        abort_run();
    endtask

    function automatic logic [31:0] masked_merge(input logic [31:0] old, mask, data);
        return (data & mask) | (old & ~mask);
    endfunction

    // ADEF, then INE, BRK, SYS, INT
    function automatic logic [14:0] expected_code(input logic [EXC_W-1:0] vec);
        if (vec[EXC_ADEF]) return {9'h000, 6'h08};
        if (vec[EXC_INE])  return {9'h000, 6'h0d};
        if (vec[EXC_BRK])  return {9'h000, 6'h0c};
        if (vec[EXC_SYS])  return {9'h000, 6'h0b};
        return 15'h0000;
    endfunction

    function automatic logic [12:0] is_expected();
        return 13'(exp_soft) | (13'(exp_tpend) << 11);
    endfunction

    function automatic logic [31:0] estat_expected();
        return {1'b0, exp_subcode, exp_ecode, 3'b000, is_expected()};
    endfunction

    function automatic logic irq_expected();
        return exp_crmd[2] & |(is_expected() & exp_lie);
    endfunction

    `include "csr_tb_tasks.svh"

    assert property (@(posedge clk) disable iff (reset) flush == (exc_valid || ertn))
        else report_mismatch("flush", 32'($sampled(exc_valid || ertn)), 32'($sampled(flush)));
    assert property (@(posedge clk) disable iff (reset)
                     !(exc_valid || ertn) |-> exception_pc == '0)
        else report_mismatch("exception_pc", 32'h0, $sampled(exception_pc));

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: sequence still running after %0d cycles", cycle_count);
            abort_run();
        end
    end

    initial begin
        logic [31:0]      data;
        logic [31:0]      mask;
        logic [EXC_W-1:0] vec;

        void'($urandom(32'ha3b1_c3de));
        {reset, csr_we, exc_valid, ertn} = 4'b1000;
        csr_num   = '0;
        csr_mask  = '0;
        csr_wdata = '0;
        exc_vec   = '0;
        exc_pc    = '0;
        for (int k = 0; k < SAVE_N; k++)
            exp_save[k] = '0;
        {exp_era, exp_eentry, exp_prmd, exp_lie, exp_soft} = '0;
        {exp_tpend, exp_ecode, exp_subcode} = '0;
        exp_crmd = 9'h008; // DA set out of reset
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;

        assert (flush === 1'b0) else report_mismatch("flush", 32'h0, 32'(flush));
        assert (csr_interrupt === 1'b0)
            else report_mismatch("csr_interrupt", 32'h0, 32'(csr_interrupt));
        csr_check(CSR_CRMD, 32'h8, "crmd");
        csr_check(CSR_PRMD, 32'h0, "prmd");
        csr_check(CSR_ERA, 32'h0, "era");
        csr_check(CSR_EENTRY, 32'h0, "eentry");
        csr_check(CSR_ECFG, 32'h0, "ecfg");
        csr_check(CSR_TVAL, 32'hffff_ffff, "tval");
        for (int k = 0; k < SAVE_N; k++)
            csr_check(CSR_NUM_W'(CSR_SAVE0 + k), 32'h0, "save");

        repeat (2) begin
            for (int k = 0; k < SAVE_N; k++) begin
                data = $urandom;
                mask = $urandom;
                csr_write(CSR_NUM_W'(CSR_SAVE0 + k), mask, data);
                exp_save[k] = masked_merge(exp_save[k], mask, data);
                csr_check(CSR_NUM_W'(CSR_SAVE0 + k), exp_save[k], "save");
            end
            data = $urandom;
            mask = $urandom;
            csr_write(CSR_ERA, mask, data);
            exp_era = masked_merge(exp_era, mask, data);
            csr_check(CSR_ERA, exp_era, "era");
            data = $urandom;
            mask = $urandom;
            csr_write(CSR_EENTRY, mask, data);
            exp_eentry = masked_merge(exp_eentry, mask, data) & ~32'h3f;
            csr_check(CSR_EENTRY, exp_eentry, "eentry");
            data = $urandom | 32'h400;
            mask = $urandom | 32'h400;
            csr_write(CSR_ECFG, mask, data);
            exp_lie = masked_merge(32'(exp_lie), mask, data) & ~13'h0400; // Bit 10 reserved
            csr_check(CSR_ECFG, 32'(exp_lie), "ecfg");
            data = $urandom;
            csr_write(CSR_CRMD, 32'h1ff, data);
            exp_crmd = data[8:0];
            csr_check(CSR_CRMD, 32'(exp_crmd), "crmd");
        end
        csr_check(14'h3ff, 32'h0, "unused csr");
        csr_check(CSR_TICLR, 32'h0, "ticlr");

        // Single causes first, then mixed vectors
        for (int n = 0; n < 8; n++) begin
            data = $urandom;
            csr_write(CSR_CRMD, 32'h7, data);
            exp_crmd[2:0] = data[2:0];
            vec = (n < 5) ? EXC_W'(1 << n) : (n == 5) ? 5'b10101 : EXC_W'($urandom);
            if (vec == '0)
                vec = 5'b00110;
            take_exception(vec, $urandom);
            csr_check(CSR_ERA, exp_era, "era");
            csr_check(CSR_PRMD, 32'(exp_prmd), "prmd");
            csr_check(CSR_CRMD, 32'(exp_crmd), "crmd");
            csr_check(CSR_ESTAT, estat_expected(), "estat");
            take_ertn();
            csr_check(CSR_CRMD, 32'(exp_crmd), "crmd");
        end

        // One-shot, InitVal 5
        csr_write(CSR_TCFG, 32'hffff_ffff, 32'h15);
        for (int v = 20; v >= 0; v--)
            csr_check(CSR_TVAL, 32'(v), "tval");
        exp_tpend = 1'b1;
        csr_check(CSR_ESTAT, estat_expected(), "estat");
        csr_check(CSR_TVAL, 32'hffff_ffff, "tval");
        csr_check(CSR_TCFG, 32'h15, "tcfg");
        csr_check(CSR_TVAL, 32'hffff_ffff, "tval");
        csr_write(CSR_TICLR, 32'h1, 32'h1);
        exp_tpend = 1'b0;
        csr_check(CSR_ESTAT, estat_expected(), "estat");

        // Periodic, InitVal 3
        csr_write(CSR_TCFG, 32'hffff_ffff, 32'h0f);
        for (int v = 12; v >= 0; v--)
            csr_check(CSR_TVAL, 32'(v), "tval");
        exp_tpend = 1'b1;
        csr_check(CSR_TVAL, 32'd12, "tval");
        csr_check(CSR_ESTAT, estat_expected(), "estat");
        csr_write(CSR_TICLR, 32'h1, 32'h1);
        exp_tpend = 1'b0;
        csr_check(CSR_ESTAT, estat_expected(), "estat");
        for (int v = 8; v >= 0; v--)
            csr_check(CSR_TVAL, 32'(v), "tval");
        exp_tpend = 1'b1;
        csr_check(CSR_ESTAT, estat_expected(), "estat");
        csr_write(CSR_TCFG, 32'h1, 32'h0); // Stops away from zero, pending kept

        // Timer line pending in the first half, clear in the second
        for (int half = 0; half < 2; half++) begin
            for (int t = 0; t < 10; t++) begin
                data = $urandom;
                csr_write(CSR_ESTAT, 32'h3, data);
                exp_soft = data[1:0];
                data = $urandom & 32'h0803;
                csr_write(CSR_ECFG, 32'hffff_ffff, data);
                exp_lie = data[12:0];
                data = $urandom;
                csr_write(CSR_CRMD, 32'h4, data);
                exp_crmd[2] = data[2];
                check_irq();
            end
            csr_write(CSR_TICLR, 32'h1, 32'h1);
            exp_tpend = 1'b0;
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== csr_regs.f ====
+incdir+tb
logic/csr_pkg.sv
logic/csr_exc_unit.sv
logic/csr_timer.sv
logic/csr_irq.sv
logic/csr_scratch.sv
logic/csr_read_mux.sv
logic/csr_top.sv
tb/csr_tb.sv

// ==== Bender.yml ====
package:
  name: csr_regs

sources:
  - logic/csr_pkg.sv
  - logic/csr_exc_unit.sv
  - logic/csr_timer.sv
  - logic/csr_irq.sv
  - logic/csr_scratch.sv
  - logic/csr_read_mux.sv
  - logic/csr_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/csr_tb.sv
